/* Bender.yml */
package:
  name: fast_rd

sources:
  - verilog/fast_rd_mem_pkg.sv
  - verilog/fast_rd_pkt_pkg.sv
  - verilog/fast_rd_if.sv
  - verilog/rd_sequencer.sv
  - verilog/pkt_pacer.sv
  - verilog/pkt_packer.sv
  - verilog/fast_rd_top.sv
  - target: simulation
    files:
      - verif/tb_fast_rd_top.sv

/* flist.f */
verilog/fast_rd_mem_pkg.sv
verilog/fast_rd_pkt_pkg.sv
verilog/fast_rd_if.sv
verilog/rd_sequencer.sv
verilog/pkt_pacer.sv
verilog/pkt_packer.sv
verilog/fast_rd_top.sv
verif/tb_fast_rd_top.sv

/* verif/tb_fast_rd_top.sv */
// Testbench for the fast readout engine with storage model, packet checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_fast_rd_top;

    localparam int NUM_CHIPS      = 96;
    localparam int CHIP_DW        = 9;
    localparam int ADDR_W         = 15;
    localparam int N_REQ          = 32;
    localparam int TIMEOUT_CYCLES = 1000 * 16 * N_REQ;

    logic                          clk;
    logic                          rstn;
    logic                          fast_rd_en;
    logic [NUM_CHIPS*CHIP_DW-1:0]  data_out;
    logic                          rf_96path_en;
    logic [1:0]                    rf_pkt_data_length;
    logic [1:0]                    rf_pkt_idle_length;
    logic [NUM_CHIPS-1:0]          fast_rd_chip_en;
    logic [NUM_CHIPS*ADDR_W-1:0]   fast_rd_raddr;
    logic [17:0]                   fast_pkt_data;
    logic                          fast_pkt_data_valid;
    logic                          fast_rd_done;

    logic                          started;
    logic                          pkt_active;
    logic [NUM_CHIPS-1:0]          en_q;
    logic [NUM_CHIPS*ADDR_W-1:0]   addr_q;
    int                            beat_cnt;
    int                            rd_idx;
    int                            run_len;
    int                            idle_len;
    logic                          seen_burst;
    int                            err_idle;
    int                            err_data;
    int                            err_len;
    int                            err_burst;
    int                            err_enable;
    integer                        seed;

    fast_rd_top #(
        .ADDR_W      (ADDR_W),
        .SYNC_STAGES (2)
    ) i_fast_rd_top (
        .clk                 (clk),
        .rstn                (rstn),
        .fast_rd_en          (fast_rd_en),
        .data_out            (data_out),
        .rf_96path_en        (rf_96path_en),
        .rf_pkt_data_length  (rf_pkt_data_length),
        .rf_pkt_idle_length  (rf_pkt_idle_length),
        .fast_rd_chip_en     (fast_rd_chip_en),
        .fast_rd_raddr       (fast_rd_raddr),
        .fast_pkt_data       (fast_pkt_data),
        .fast_pkt_data_valid (fast_pkt_data_valid),
        .fast_rd_done        (fast_rd_done)
    );

    // ------------------------------
    // Expected values
    // ------------------------------
    function automatic logic [CHIP_DW-1:0] model_word(input int chip, input int addr);
        return CHIP_DW'((7 * chip + addr) % 512);
    endfunction

    // Beat k of a packet carries chips 2j and 2j+1 of row k/48
    function automatic logic [17:0] exp_beat(input int k);
        int r;
        int j;
        r = k / 48;
        j = k % 48;
        return {model_word(2 * j + 1, r), model_word(2 * j, r)};
    endfunction

    function automatic int beats_per_pkt(input logic [1:0] len);
        return 96 << len;
    endfunction

    function automatic int reads_per_pkt(input logic full, input logic [1:0] len);
        return full ? (2 << len) : (4 << len);
    endfunction

    function automatic int min_gap(input logic [1:0] code);
        return 2 << code;
    endfunction

    function automatic int burst_len(input logic full);
        return full ? 48 : 24;
    endfunction

    function automatic logic [NUM_CHIPS-1:0] exp_enables(input logic full, input logic upper);
        if (full) begin
            return '1;
        end
        return upper ? {{48{1'b1}}, 48'd0} : {48'd0, {48{1'b1}}};
    endfunction

    function automatic logic [NUM_CHIPS*ADDR_W-1:0] addr_bus(input int addr);
        logic [NUM_CHIPS*ADDR_W-1:0] bus;
        for (int c = 0; c < NUM_CHIPS; c++) begin
            bus[c*ADDR_W +: ADDR_W] = ADDR_W'(addr);
        end
        return bus;
    endfunction

    // ------------------------------
    // Clock, storage model, trackers
    // ------------------------------
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Memory answers one cycle after enable
    always @(posedge clk) begin
        en_q   <= fast_rd_chip_en;
        addr_q <= fast_rd_raddr;
    end

    always @(negedge clk) begin
        for (int c = 0; c < NUM_CHIPS; c++) begin
            data_out[c*CHIP_DW +: CHIP_DW] <= en_q[c] ?
                model_word(c, int'(addr_q[c*ADDR_W +: ADDR_W])) : '0;
        end
    end

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt   <= 0;
            rd_idx     <= 0;
            run_len    <= 0;
            idle_len   <= 0;
            seen_burst <= 1'b0;
        end else begin
            if (fast_rd_done) begin
                beat_cnt   <= 0;
                rd_idx     <= 0;
                seen_burst <= 1'b0;
            end else begin
                if (fast_pkt_data_valid) beat_cnt <= beat_cnt + 1;
                if (|fast_rd_chip_en) rd_idx <= rd_idx + 1;
                if (!fast_pkt_data_valid && run_len != 0) seen_burst <= 1'b1;
            end
            run_len  <= fast_pkt_data_valid ? run_len + 1 : 0;
            idle_len <= fast_pkt_data_valid ? 0 : idle_len + 1;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    a_reset_values: assert property (@(posedge clk) disable iff (!rstn)
        !started |-> (fast_rd_chip_en == '0 && !fast_pkt_data_valid && !fast_rd_done &&
                      fast_pkt_data == '0 && fast_rd_raddr == '0))
        else begin
            err_idle++;
            $display("outputs left their reset values before any request");
        end

    a_beat_data: assert property (@(posedge clk) disable iff (!rstn)
        fast_pkt_data_valid |-> fast_pkt_data == exp_beat(beat_cnt))
        else begin
            err_data++;
            $display("error fast_pkt_data: got %h expected %h", $sampled(fast_pkt_data),
                     exp_beat($sampled(beat_cnt)));
        end

    a_pkt_length: assert property (@(posedge clk) disable iff (!rstn)
        fast_rd_done |-> (pkt_active && beat_cnt == beats_per_pkt(rf_pkt_data_length) &&
                          rd_idx == reads_per_pkt(rf_96path_en, rf_pkt_data_length)))
        else begin
            err_len++;
            $display("done pulse after %0d beats and %0d reads, outside a packet or early",
                     $sampled(beat_cnt), $sampled(rd_idx));
        end

    a_burst_max: assert property (@(posedge clk) disable iff (!rstn)
        fast_pkt_data_valid |-> run_len < burst_len(rf_96path_en))
        else begin
            err_burst++;
            $display("burst ran longer than one row");
        end

    a_burst_end: assert property (@(posedge clk) disable iff (!rstn)
        $fell(fast_pkt_data_valid) |-> run_len == burst_len(rf_96path_en))
        else begin
            err_burst++;
            $display("burst of %0d beats was cut short", $sampled(run_len));
        end

    a_gap_min: assert property (@(posedge clk) disable iff (!rstn)
        ($rose(fast_pkt_data_valid) && seen_burst) |-> idle_len >= min_gap(rf_pkt_idle_length))
        else begin
            err_burst++;
            $display("idle gap of %0d cycles is too short", $sampled(idle_len));
        end

    a_enable_mask: assert property (@(posedge clk) disable iff (!rstn)
        (|fast_rd_chip_en) |-> (pkt_active &&
                                fast_rd_chip_en == exp_enables(rf_96path_en, rd_idx[0])))
        else begin
            err_enable++;
            $display("error fast_rd_chip_en: got %h expected %h", $sampled(fast_rd_chip_en),
                     exp_enables($sampled(rf_96path_en), $sampled(rd_idx[0])));
        end

    // Both halves of a read pair share one row address
    a_enable_addr: assert property (@(posedge clk) disable iff (!rstn)
        (|fast_rd_chip_en) |->
            fast_rd_raddr == addr_bus(rf_96path_en ? rd_idx : rd_idx / 2))
        else begin
            err_enable++;
            $display("error fast_rd_raddr: got %h expected %h", $sampled(fast_rd_raddr),
                     addr_bus($sampled(rf_96path_en) ? $sampled(rd_idx) : $sampled(rd_idx) / 2));
        end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic run_packet(input logic [4:0] combo);
        int   delay;
        logic extra;
        rf_96path_en       = combo[4];
        rf_pkt_data_length = combo[3:2];
        rf_pkt_idle_length = combo[1:0];
        @(negedge clk);
        started    = 1'b1;
        pkt_active = 1'b1;
        fast_rd_en = 1'b1;
        @(negedge clk);
        fast_rd_en = 1'b0;
        extra = $random(seed);
        delay = 5 + ($unsigned($random(seed)) % 32);
        // A second request in mid packet must be dropped
        if (extra) begin
            while (!(|fast_rd_chip_en)) @(negedge clk);
            repeat (delay) @(negedge clk);
            fast_rd_en = 1'b1;
            @(negedge clk);
            fast_rd_en = 1'b0;
        end
        while (!fast_rd_done) @(negedge clk);
        // Packet stays open through the whole done cycle
        @(negedge clk);
        pkt_active = 1'b0;
        repeat (20) @(negedge clk);
    endtask

    initial begin
        logic [4:0] order [N_REQ];
        logic [4:0] tmp;
        int         j;
        seed               = 32'hea0c;
        rstn               = 1'b0;
        fast_rd_en         = 1'b0;
        data_out           = '0;
        rf_96path_en       = 1'b1;
        rf_pkt_data_length = 2'd0;
        rf_pkt_idle_length = 2'd0;
        started            = 1'b0;
        pkt_active         = 1'b0;
        err_idle           = 0;
        err_data           = 0;
        err_len            = 0;
        err_burst          = 0;
        err_enable         = 0;
        for (int i = 0; i < N_REQ; i++) order[i] = 5'(i);
        // Shuffle mode, length and gap combinations
        for (int i = N_REQ - 1; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        repeat (10) @(negedge clk);
        for (int i = 0; i < N_REQ; i++) run_packet(order[i]);
        $display("errors: idle %0d data %0d length %0d burst %0d enable %0d",
                 err_idle, err_data, err_len, err_burst, err_enable);
        if (err_idle + err_data + err_len + err_burst + err_enable == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired before all packets completed");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/fast_rd_if.sv */
// Row capture and beat slot interfaces between sequencer, pacer and packer
`timescale 1ns/1ps
`default_nettype none

// ------------------------------
// Sequencer to packer
// ------------------------------
interface rd_row_if;
    logic cap;
    logic half;
    logic last;
    logic row_free;
    logic pkt_done;

    modport seq (
        output cap,
        output half,
        output last,
        input  row_free,
        input  pkt_done
    );

    modport pack (
        input  cap,
        input  half,
        input  last,
        output row_free,
        output pkt_done
    );
endinterface

// ------------------------------
// Pacer to packer
// ------------------------------
interface beat_slot_if;
    import fast_rd_pkt_pkg::*;

    logic      row_ready;
    logic      row_last;
    logic      beat_en;
    beat_idx_t beat_idx;
    logic      row_end;

    modport pace (input row_ready, input row_last, output beat_en, output beat_idx, output row_end);
    modport pack (output row_ready, output row_last, input beat_en, input beat_idx, input row_end);
endinterface

`default_nettype wire

/* verilog/fast_rd_mem_pkg.sv */
// Storage array geometry, chip read word and row address helpers for fast readout
`default_nettype none

package fast_rd_mem_pkg;

    // Array geometry
    localparam int NUM_CHIPS  = 96;
    localparam int HALF_CHIPS = 48;
    localparam int CHIP_DW    = 9;

    typedef logic [CHIP_DW-1:0] chip_word_t;

    // Chip 0 sits in the lowest word
    typedef chip_word_t [NUM_CHIPS-1:0] row_data_t;

    // Chip enable pattern for one read, whole array or one half
    function automatic logic [NUM_CHIPS-1:0] chip_en_mask(input logic full,
                                                          input logic upper);
        logic [NUM_CHIPS-1:0] mask;
        mask = '0;
        if (full) begin
            mask = '1;
        end else if (upper) begin
            mask[NUM_CHIPS-1:HALF_CHIPS] = '1;
        end else begin
            mask[HALF_CHIPS-1:0] = '1;
        end
        return mask;
    endfunction

    // Row address of a read, both halves of a pair share one row
    function automatic logic [5:0] read_row(input logic [5:0] rd_idx, input logic half_mode);
        return half_mode ? {1'b0, rd_idx[5:1]} : rd_idx;
    endfunction

endpackage

`default_nettype wire

/* verilog/fast_rd_pkt_pkg.sv */
// Packet format for fast readout: length and gap codes, beat types and chip pairs
`default_nettype none

package fast_rd_pkt_pkg;

    localparam int BEAT_W = 2 * fast_rd_mem_pkg::CHIP_DW;

    // Packet length, 216 bytes doubling up to 1728
    typedef enum logic [1:0] {
        LEN_216B  = 2'd0,
        LEN_432B  = 2'd1,
        LEN_864B  = 2'd2,
        LEN_1728B = 2'd3
    } pkt_len_e;

    // Minimum idle gap between bursts
    typedef enum logic [1:0] {
        GAP_2  = 2'd0,
        GAP_4  = 2'd1,
        GAP_8  = 2'd2,
        GAP_16 = 2'd3
    } idle_len_e;

    typedef logic [5:0] beat_idx_t;

    // One beat, seen raw or as an even/odd chip pair
    typedef union packed {
        logic [BEAT_W-1:0] raw;
        struct packed {
            fast_rd_mem_pkg::chip_word_t hi;
            fast_rd_mem_pkg::chip_word_t lo;
        } pair;
    } chip_pair_u;

    // Reads per packet, twice as many when only half the chips are read
    function automatic logic [5:0] rows_per_pkt(input pkt_len_e len, input logic half_mode);
        logic [5:0] rows;
        rows = 6'd2 << len;
        return half_mode ? (rows << 1) : rows;
    endfunction

    function automatic logic [4:0] gap_cycles(input idle_len_e code);
        return 5'd2 << code;
    endfunction

endpackage

`default_nettype wire

/* verilog/fast_rd_top.sv */
// Fast readout top level joining read sequencer, packet pacer and packer
`timescale 1ns/1ps
`default_nettype none

module fast_rd_top #(
    parameter int ADDR_W      = 15,
    parameter int SYNC_STAGES = 2
) (
    input  logic                                          clk,
    input  logic                                          rstn,
    input  logic                                          fast_rd_en,
    input  logic [fast_rd_mem_pkg::NUM_CHIPS*fast_rd_mem_pkg::CHIP_DW-1:0] data_out,
    input  logic                                          rf_96path_en,
    input  logic [1:0]                                    rf_pkt_data_length,
    input  logic [1:0]                                    rf_pkt_idle_length,
    output logic [fast_rd_mem_pkg::NUM_CHIPS-1:0]         fast_rd_chip_en,
    output logic [fast_rd_mem_pkg::NUM_CHIPS*ADDR_W-1:0]  fast_rd_raddr,
    output logic [fast_rd_pkt_pkg::BEAT_W-1:0]            fast_pkt_data,
    output logic                                          fast_pkt_data_valid,
    output logic                                          fast_rd_done
);
    import fast_rd_pkt_pkg::*;

    rd_row_if    i_row_if ();
    beat_slot_if i_slot_if ();

    rd_sequencer #(
        .ADDR_W      (ADDR_W),
        .SYNC_STAGES (SYNC_STAGES)
    ) i_rd_sequencer (
        .clk                (clk),
        .rstn               (rstn),
        .fast_rd_en         (fast_rd_en),
        .rf_96path_en       (rf_96path_en),
        .rf_pkt_data_length (pkt_len_e'(rf_pkt_data_length)),
        .fast_rd_chip_en    (fast_rd_chip_en),
        .fast_rd_raddr      (fast_rd_raddr),
        .fast_rd_done       (fast_rd_done),
        .row                (i_row_if.seq)
    );

    pkt_pacer i_pkt_pacer (
        .clk                (clk),
        .rstn               (rstn),
        .rf_96path_en       (rf_96path_en),
        .rf_pkt_idle_length (idle_len_e'(rf_pkt_idle_length)),
        .slot               (i_slot_if.pace)
    );

    // Flat memory bus maps onto the row type, chip 0 lowest
    pkt_packer i_pkt_packer (
        .clk                 (clk),
        .rstn                (rstn),
        .data_out            (data_out),
        .rf_96path_en        (rf_96path_en),
        .fast_pkt_data       (fast_pkt_data),
        .fast_pkt_data_valid (fast_pkt_data_valid),
        .row                 (i_row_if.pack),
        .slot                (i_slot_if.pack)
    );

endmodule

`default_nettype wire

/* verilog/pkt_pacer.sv */
// Packet pacer: times beat slots of each row and idle gaps between bursts
`timescale 1ns/1ps
`default_nettype none

module pkt_pacer (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         rf_96path_en,
    input  fast_rd_pkt_pkg::idle_len_e   rf_pkt_idle_length,
    beat_slot_if.pace                    slot
);
    import fast_rd_pkt_pkg::*;

    typedef enum logic [1:0] {
        PKT_IDLE,
        PKT_VALID,
        PKT_GAP
    } pkt_state_e;

    pkt_state_e state;
    pkt_state_e state_nxt;
    beat_idx_t  beat_cnt;
    beat_idx_t  beat_max;
    logic [4:0] gap_cnt;

    // 48 beats per full row, 24 per half
    assign beat_max = rf_96path_en ? beat_idx_t'(47) : beat_idx_t'(23);

    assign slot.beat_en  = (state == PKT_VALID);
    assign slot.beat_idx = beat_cnt;
    assign slot.row_end  = (state == PKT_VALID) && (beat_cnt == beat_max);

    always_comb begin
        state_nxt = state;
        case (state)
            PKT_IDLE: begin
                if (slot.row_ready) begin
                    state_nxt = PKT_VALID;
                end
            end
            PKT_VALID: begin
                if (slot.row_end) begin
                    state_nxt = slot.row_last ? PKT_IDLE : PKT_GAP;
                end
            end
            PKT_GAP: begin
                if (gap_cnt == 5'd0) begin
                    state_nxt = slot.row_ready ? PKT_VALID : PKT_IDLE;
                end
            end
            default: begin
                state_nxt = PKT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= PKT_IDLE;
            beat_cnt <= '0;
            gap_cnt  <= '0;
        end else begin
            state <= state_nxt;
            if (slot.row_end) begin
                beat_cnt <= '0;
                gap_cnt  <= gap_cycles(rf_pkt_idle_length) - 5'd1;
            end else if (state == PKT_VALID) begin
                beat_cnt <= beat_cnt + beat_idx_t'(1);
            end else if ((state == PKT_GAP) && (gap_cnt != 5'd0)) begin
                gap_cnt <= gap_cnt - 5'd1;
            end
        end
    end

    a_beat_has_row: assert property (@(posedge clk) disable iff (!rstn)
        slot.beat_en |-> slot.row_ready)
        else $error("beat slot issued with no row in the buffer");

endmodule

`default_nettype wire

/* verilog/pkt_packer.sv */
// Packet packer: row buffer capture and 18-bit beat forming in the pacer slots
`timescale 1ns/1ps
`default_nettype none

module pkt_packer (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  fast_rd_mem_pkg::row_data_t            data_out,
    input  logic                                  rf_96path_en,
    output logic [fast_rd_pkt_pkg::BEAT_W-1:0]    fast_pkt_data,
    output logic                                  fast_pkt_data_valid,
    rd_row_if.pack                                row,
    beat_slot_if.pack                             slot
);
    import fast_rd_mem_pkg::*;
    import fast_rd_pkt_pkg::*;

    row_data_t  row_buf;
    logic       buf_half;
    logic       row_ready_q;
    logic       row_last_q;
    logic       row_drain;
    beat_idx_t  pair_idx;
    logic [6:0] lo_idx;
    chip_pair_u beat_word;

    // Final beat of the buffered row leaves this cycle
    assign row_drain = slot.beat_en & slot.row_end;

    assign slot.row_ready = row_ready_q;
    assign slot.row_last  = row_last_q;
    assign row.row_free   = ~row.cap & (~row_ready_q | row_drain);

    // ------------------------------
    // Row buffer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (row.cap) begin
            if (rf_96path_en) begin
                row_buf <= data_out;
            end else if (row.half) begin
                row_buf[NUM_CHIPS-1:HALF_CHIPS] <= data_out[NUM_CHIPS-1:HALF_CHIPS];
            end else begin
                row_buf[HALF_CHIPS-1:0] <= data_out[HALF_CHIPS-1:0];
            end
        end
    end

    // Upper half beats start at chip 48
    assign pair_idx = (!rf_96path_en && buf_half) ?
                      slot.beat_idx + beat_idx_t'(HALF_CHIPS / 2) : slot.beat_idx;
    assign lo_idx   = {pair_idx, 1'b0};

    always_comb begin
        beat_word.pair.lo = row_buf[lo_idx];
        beat_word.pair.hi = row_buf[lo_idx + 7'd1];
    end

    // ------------------------------
    // Beat output and row status
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fast_pkt_data       <= '0;
            fast_pkt_data_valid <= 1'b0;
            row.pkt_done        <= 1'b0;
            row_ready_q         <= 1'b0;
            row_last_q          <= 1'b0;
            buf_half            <= 1'b0;
        end else begin
            fast_pkt_data_valid <= slot.beat_en;
            if (slot.beat_en) begin
                fast_pkt_data <= beat_word.raw;
            end
            row.pkt_done <= row_drain & row_last_q;
            if (row.cap) begin
                row_ready_q <= 1'b1;
                row_last_q  <= row.last;
                buf_half    <= row.half;
            end else if (row_drain) begin
                row_ready_q <= 1'b0;
            end
        end
    end

    a_cap_into_free: assert property (@(posedge clk) disable iff (!rstn)
        row.cap |-> !(row_ready_q && !slot.row_end))
        else $error("row captured over an undrained buffer");

endmodule

`default_nettype wire

/* verilog/rd_sequencer.sv */
// Read sequencer: request sync, read FSM, chip enables, row addresses and done pulse
`timescale 1ns/1ps
`default_nettype none

module rd_sequencer #(
    parameter int ADDR_W      = 15,
    parameter int SYNC_STAGES = 2
) (
    input  logic                                          clk,
    input  logic                                          rstn,
    input  logic                                          fast_rd_en,
    input  logic                                          rf_96path_en,
    input  fast_rd_pkt_pkg::pkt_len_e                     rf_pkt_data_length,
    output logic [fast_rd_mem_pkg::NUM_CHIPS-1:0]         fast_rd_chip_en,
    output logic [fast_rd_mem_pkg::NUM_CHIPS*ADDR_W-1:0]  fast_rd_raddr,
    output logic                                          fast_rd_done,
    rd_row_if.seq                                         row
);
    import fast_rd_mem_pkg::*;
    import fast_rd_pkt_pkg::*;

    typedef enum logic [1:0] {
        READ_IDLE,
        READ_ISSUE,
        READ_WAIT,
        READ_DONE
    } read_state_e;

    read_state_e          state;
    read_state_e          state_nxt;
    logic [SYNC_STAGES:0] sync_q;
    logic                 req;
    logic                 issue;
    logic [5:0]           rd_cnt;
    logic [5:0]           rd_total;
    logic                 rd_half;
    logic                 rd_last;
    logic [5:0]           rd_row;

    // ------------------------------
    // Request synchronizer
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-1:0], fast_rd_en};
        end
    end

    // Rising edge of the synchronized request
    assign req = sync_q[SYNC_STAGES-1] & ~sync_q[SYNC_STAGES];

    // Current read
    assign rd_total = rows_per_pkt(rf_pkt_data_length, ~rf_96path_en);
    assign rd_half  = ~rf_96path_en & rd_cnt[0];
    assign rd_last  = (rd_cnt == rd_total - 6'd1);
    assign rd_row   = read_row(rd_cnt, ~rf_96path_en);

    // ------------------------------
    // Read FSM
    // ------------------------------
    always_comb begin
        state_nxt = state;
        issue     = 1'b0;
        case (state)
            READ_IDLE: begin
                // Requests outside idle are dropped
                if (req) begin
                    issue     = row.row_free;
                    state_nxt = row.row_free ? READ_WAIT : READ_ISSUE;
                end
            end
            READ_ISSUE: begin
                if (row.row_free) begin
                    issue     = 1'b1;
                    state_nxt = READ_WAIT;
                end
            end
            READ_WAIT: begin
                state_nxt = rd_last ? READ_DONE : READ_ISSUE;
            end
            READ_DONE: begin
                if (row.pkt_done) begin
                    state_nxt = READ_IDLE;
                end
            end
            default: begin
                state_nxt = READ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state           <= READ_IDLE;
            rd_cnt          <= '0;
            fast_rd_chip_en <= '0;
            fast_rd_raddr   <= '0;
            fast_rd_done    <= 1'b0;
            row.cap         <= 1'b0;
            row.half        <= 1'b0;
            row.last        <= 1'b0;
        end else begin
            state        <= state_nxt;
            fast_rd_done <= (state == READ_DONE) && row.pkt_done;
            // Memory answers one cycle after the enable
            row.cap      <= (state == READ_WAIT);
            if (issue) begin
                fast_rd_chip_en <= chip_en_mask(rf_96path_en, rd_half);
                fast_rd_raddr   <= {NUM_CHIPS{ADDR_W'(rd_row)}};
            end else begin
                fast_rd_chip_en <= '0;
            end
            if (state == READ_WAIT) begin
                row.half <= rd_half;
                row.last <= rd_last;
                rd_cnt   <= rd_cnt + 6'd1;
            end else if ((state == READ_DONE) && row.pkt_done) begin
                rd_cnt <= '0;
            end
        end
    end

    // Each read needs a free row buffer one cycle earlier
    a_en_needs_free: assert property (@(posedge clk) disable iff (!rstn)
        $rose(|fast_rd_chip_en) |-> $past(row.row_free))
        else $error("chip enable raised while the row buffer was busy");

    a_no_cap_idle: assert property (@(posedge clk) disable iff (!rstn)
        row.cap |-> (state != READ_IDLE))
        else $error("capture strobe seen in READ_IDLE");

endmodule

`default_nettype wire
